//--- design/stashPkg.sv
/*
 Tree geometry, block layout and FSM state encoding shared by the stash
 modules and the testbench. Import it wherever a block or a state is used.
*/
package stashPkg;

	// --------------------------------------------------
	// Tree geometry
	// --------------------------------------------------

	// Leaf bits, also the index of the deepest level
	localparam int ORAML = 3;

	// Block slots in each bucket
	localparam int BucketZ = 2;

	// Slots on one root-to-leaf path
	localparam int BlocksOnPath = (ORAML + 1) * BucketZ;

	// --------------------------------------------------
	// Block format
	// --------------------------------------------------

	// Address 0 is reserved for dummy blocks
	localparam int PAddrWidth = 8;
	localparam int DataWidth = 32;

	// One block, as it moves between decrypt, stash and encrypt
	typedef struct packed {
		logic [PAddrWidth-1:0] paddr;
		logic [ORAML-1:0] leaf;
		logic [DataWidth-1:0] data;
	} stashBlock;

	// Frontend return word
	typedef struct packed {
		logic hit;
		stashBlock block;
	} returnInfo;

	// --------------------------------------------------
	// Access FSM
	// --------------------------------------------------

	typedef enum logic [2:0] {
		stateReset,
		stateIdle,
		statePathRead,
		stateLookup,
		stateWriteback
	} stashState;

endpackage

//--- design/stashCore.sv
/*
 Stash block storage. Real blocks land in the lowest free slot, lookups walk
 the slots one per cycle, and writeback reads slots by index and frees them.
*/
module stashCore #(
	parameter int StashCapacity = 16,
	localparam int SLOT_INDEX_WIDTH = $clog2(StashCapacity),
	localparam int CountWidth = $clog2(StashCapacity + 1)
) (
	input logic Clock,
	input logic reset,

	// Allocation from the path read
	input stashPkg::stashBlock coreWrite,
	input logic coreWriteEnable,

	// Lookup and remap
	input logic [stashPkg::PAddrWidth-1:0] lookupPAddr,
	input logic lookupStart,
	input logic [stashPkg::ORAML-1:0] remapLeaf,
	output logic lookupDone,
	output logic lookupHit,
	output logic [SLOT_INDEX_WIDTH-1:0] lookupSlot,
	output stashPkg::stashBlock lookupBlock,

	// Slot state toward the scan table
	output logic [StashCapacity-1:0] slotValids,
	output logic [StashCapacity-1:0][stashPkg::ORAML-1:0] slotLeaves,

	// Writeback read port
	input logic [SLOT_INDEX_WIDTH-1:0] slotRead,
	input logic slotReadEnable,
	input logic slotFree,
	output stashPkg::stashBlock slotBlock,

	// Fill level
	output logic [CountWidth-1:0] occupancy,
	output logic full
);
	import stashPkg::*;

	// Payload, no reset needed
	stashBlock slotData [StashCapacity];

	stashState phase;
	logic [SLOT_INDEX_WIDTH-1:0] scanIndex;
	logic [SLOT_INDEX_WIDTH-1:0] freeSlot;
	logic scanMatch;
	logic allocate;
	logic freeing;

	// --------------------------------------------------
	// Allocation
	// --------------------------------------------------

	assign full = &slotValids;
	assign allocate = coreWriteEnable && !full;
	assign freeing = slotReadEnable && slotFree;

	// Lowest free slot wins
	always_comb begin
		freeSlot = '0;
		for (int i = StashCapacity - 1; i >= 0; i--) begin
			if (!slotValids[i]) begin
				freeSlot = SLOT_INDEX_WIDTH'(i);
			end
		end
	end

	// Valid bits, cleared on reset
	always_ff @(posedge Clock) begin
		if (reset) begin
			slotValids <= '0;
		end else begin
			if (allocate) begin
				slotValids[freeSlot] <= 1'b1;
			end
			if (freeing) begin
				slotValids[slotRead] <= 1'b0;
			end
		end
	end

	// Running count instead of a popcount
	always_ff @(posedge Clock) begin
		if (reset) begin
			occupancy <= '0;
		end else begin
			case ({allocate, freeing})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	// --------------------------------------------------
	// Lookup walk
	// --------------------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			phase <= stateReset;
			scanIndex <= '0;
		end else begin
			case (phase)
				// Valid bits cleared during reset, one more cycle to settle
				stateReset: phase <= stateIdle;
				stateIdle: begin
					if (lookupStart) begin
						phase <= stateLookup;
						scanIndex <= '0;
					end
				end
				stateLookup: begin
					if (lookupDone) begin
						phase <= stateIdle;
					end else begin
						scanIndex <= scanIndex + 1'b1;
					end
				end
				default: phase <= stateIdle;
			endcase
		end
	end

	assign scanMatch = slotValids[scanIndex] && (slotData[scanIndex].paddr == lookupPAddr);

	// Stop on a hit or after the last slot
	assign lookupDone = (phase == stateLookup)
		&& (scanMatch || scanIndex == SLOT_INDEX_WIDTH'(StashCapacity - 1));
	assign lookupHit = (phase == stateLookup) && scanMatch;
	assign lookupSlot = scanIndex;
	// Block as stored, before the remap lands
	assign lookupBlock = scanMatch ? slotData[scanIndex] : '0;

	// --------------------------------------------------
	// Payload writes and remap
	// --------------------------------------------------

	always_ff @(posedge Clock) begin
		if (allocate) begin
			slotData[freeSlot] <= coreWrite;
		end
		// New leaf written in the cycle the hit is reported
		if (lookupHit) begin
			slotData[scanIndex].leaf <= remapLeaf;
		end
	end

	always_comb begin
		for (int i = 0; i < StashCapacity; i++) begin
			slotLeaves[i] = slotData[i].leaf;
		end
	end

	assign slotBlock = slotReadEnable ? slotData[slotRead] : '0;

	// Top drops real blocks itself once the stash is full, and never writes mid-lookup
	assert property (@(posedge Clock) disable iff (reset)
		coreWriteEnable |-> !full && phase != stateLookup);

endmodule

//--- design/stashScanTable.sv
/*
 Writeback slot picker. For each output position of the path it names the
 lowest stash slot that may live in the current bucket, or asks for a dummy.
*/
module stashScanTable #(
	parameter int StashCapacity = 16,
	localparam int SLOT_INDEX_WIDTH = $clog2(StashCapacity)
) (
	input logic Clock,
	input logic reset,
	input logic [stashPkg::ORAML-1:0] AccessLeaf,

	// Slot state from the core
	input logic [StashCapacity-1:0] slotValids,
	input logic [StashCapacity-1:0][stashPkg::ORAML-1:0] slotLeaves,

	// Writeback stepping from the top
	input logic assignStart,
	input logic nextSlot,
	output logic assignValid,
	output logic [SLOT_INDEX_WIDTH-1:0] assignSlot,
	output logic assignDummy
);
	import stashPkg::*;

	localparam int LevelWidth = $clog2(ORAML + 1);
	localparam int PosWidth = (BucketZ > 1) ? $clog2(BucketZ) : 1;

	logic [StashCapacity-1:0] takenMask;
	logic [StashCapacity-1:0] eligible;
	logic [StashCapacity-1:0] candidates;
	logic [LevelWidth-1:0] level;
	logic [PosWidth-1:0] bucketPos;

	// Deepest shared level, leaf bit 0 picks the child of the root
	function automatic logic [LevelWidth-1:0] commonDepth(
		input logic [ORAML-1:0] slotLeaf,
		input logic [ORAML-1:0] pathLeaf
	);
		logic [LevelWidth-1:0] depth;
		depth = LevelWidth'(ORAML);
		// Walk down so the lowest mismatching bit wins
		for (int b = ORAML - 1; b >= 0; b--) begin
			if (slotLeaf[b] != pathLeaf[b]) begin
				depth = LevelWidth'(b);
			end
		end
		return depth;
	endfunction

	// --------------------------------------------------
	// Eligibility and greedy pick
	// --------------------------------------------------

	always_comb begin
		for (int i = 0; i < StashCapacity; i++) begin
			eligible[i] = commonDepth(slotLeaves[i], AccessLeaf) >= level;
		end
	end

	assign candidates = slotValids & ~takenMask & eligible;
	assign assignDummy = ~|candidates;

	// Lowest index first
	always_comb begin
		assignSlot = '0;
		for (int i = StashCapacity - 1; i >= 0; i--) begin
			if (candidates[i]) begin
				assignSlot = SLOT_INDEX_WIDTH'(i);
			end
		end
	end

	// --------------------------------------------------
	// Position stepping, leaf bucket up to the root
	// --------------------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			assignValid <= 1'b0;
			takenMask <= '0;
			level <= '0;
			bucketPos <= '0;
		end else if (assignStart) begin
			assignValid <= 1'b1;
			takenMask <= '0;
			level <= LevelWidth'(ORAML);
			bucketPos <= '0;
		end else if (assignValid && nextSlot) begin
			if (!assignDummy) begin
				takenMask[assignSlot] <= 1'b1;
			end
			if (bucketPos == PosWidth'(BucketZ - 1)) begin
				bucketPos <= '0;
				// Root bucket done
				if (level == '0) begin
					assignValid <= 1'b0;
				end else begin
					level <= level - 1'b1;
				end
			end else begin
				bucketPos <= bucketPos + 1'b1;
			end
		end
	end

	// An assigned slot is freed by the core on the following edge
	assert property (@(posedge Clock) disable iff (reset)
		assignValid && nextSlot && !assignDummy |=> !slotValids[$past(assignSlot)]);

endmodule

//--- design/stash.sv
/*
 Path ORAM stash top level. Takes in a decrypted path, returns the requested
 block to the frontend, then writes the path back under credit flow control.
*/
module stash #(
	parameter int StashCapacity = 16,
	parameter int ReadCredits = 4
) (
	input logic Clock,
	input logic reset,

	// Access command, held while the access runs
	input logic [stashPkg::ORAML-1:0] AccessLeaf,
	input logic [stashPkg::PAddrWidth-1:0] AccessPAddr,
	input logic [stashPkg::ORAML-1:0] AccessNewLeaf,
	input logic StartAccess,

	// Decrypted path in, valid/ready
	input stashPkg::stashBlock WriteBlock,
	input logic WriteValid,
	output logic WriteReady,

	// Frontend return
	output stashPkg::returnInfo ReturnInfo,
	output logic ReturnValid,

	// Writeback toward encryption, credit based
	output stashPkg::stashBlock ReadBlock,
	output logic ReadValid,
	input logic ReadCreditReturn,

	// Status
	output logic AccessDone,
	output logic StashAlmostFull,
	output logic StashOverflow
);
	import stashPkg::*;

	localparam int SLOT_INDEX_WIDTH = $clog2(StashCapacity);
	localparam int CountWidth = $clog2(StashCapacity + 1);
	localparam int BeatWidth = $clog2(BlocksOnPath);
	localparam int CreditWidth = $clog2(ReadCredits + 1);

	stashState state, nextState;
	logic [BeatWidth-1:0] pathCount, beatCount;
	logic [CreditWidth-1:0] creditCount;
	logic writeFire, realBlock, pathLast, readBeat, beatLast;

	logic coreWriteEnable, lookupDone, lookupHit, full, assignValid, assignDummy;
	logic [SLOT_INDEX_WIDTH-1:0] lookupSlot, assignSlot;
	stashBlock lookupBlock, slotBlock;
	logic [StashCapacity-1:0] slotValids;
	logic [StashCapacity-1:0][ORAML-1:0] slotLeaves;
	logic [CountWidth-1:0] occupancy;

	// --------------------------------------------------
	// Access FSM
	// --------------------------------------------------

	assign writeFire = WriteValid && WriteReady;
	assign realBlock = WriteBlock.paddr != '0;
	assign pathLast = writeFire && pathCount == BeatWidth'(BlocksOnPath - 1);
	assign readBeat = ReadValid;
	assign beatLast = readBeat && beatCount == BeatWidth'(BlocksOnPath - 1);

	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= stateReset;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			// One cycle for the core to finish clearing
			stateReset: nextState = stateIdle;
			stateIdle: if (StartAccess) nextState = statePathRead;
			statePathRead: if (pathLast) nextState = stateLookup;
			stateLookup: if (lookupDone) nextState = stateWriteback;
			stateWriteback: if (beatLast) nextState = stateIdle;
			default: nextState = stateIdle;
		endcase
	end

	// Path blocks in and writeback beats out
	always_ff @(posedge Clock) begin
		if (reset || state != statePathRead) begin
			pathCount <= '0;
		end else if (writeFire) begin
			pathCount <= pathCount + 1'b1;
		end
		if (reset || state != stateWriteback) begin
			beatCount <= '0;
		end else if (readBeat) begin
			beatCount <= beatCount + 1'b1;
		end
	end

	assign WriteReady = state == statePathRead;
	// Dummies are taken off the bus and dropped, so are real blocks once full
	assign coreWriteEnable = writeFire && realBlock && !full;

	// --------------------------------------------------
	// Return and writeback datapath
	// --------------------------------------------------

	always_ff @(posedge Clock) begin
		ReturnValid <= !reset && state == stateLookup && lookupDone;
		AccessDone <= !reset && state == stateWriteback && beatLast;
	end

	always_ff @(posedge Clock) begin
		if (lookupDone) begin
			ReturnInfo <= '{hit: lookupHit, block: lookupBlock};
		end
	end

	assign ReadValid = state == stateWriteback && assignValid && creditCount != '0;

	// Dummy block keeps the path leaf
	always_comb begin
		ReadBlock = slotBlock;
		if (assignDummy) begin
			ReadBlock = '0;
			ReadBlock.leaf = AccessLeaf;
		end
	end

	// Credits, capped at the initial grant
	always_ff @(posedge Clock) begin
		if (reset) begin
			creditCount <= CreditWidth'(ReadCredits);
		end else if (ReadCreditReturn && !readBeat) begin
			if (creditCount != CreditWidth'(ReadCredits)) begin
				creditCount <= creditCount + 1'b1;
			end
		end else if (!ReadCreditReturn && readBeat) begin
			creditCount <= creditCount - 1'b1;
		end
	end

	// --------------------------------------------------
	// Status
	// --------------------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			StashAlmostFull <= 1'b0;
			StashOverflow <= 1'b0;
		end else begin
			StashAlmostFull <= occupancy >= CountWidth'(StashCapacity - BlocksOnPath);
			// Sticky until reset
			if (writeFire && realBlock && full) begin
				StashOverflow <= 1'b1;
			end
		end
	end

	stashCore #(.StashCapacity(StashCapacity)) core (
		.Clock(Clock),
		.reset(reset),
		.coreWrite(WriteBlock),
		.coreWriteEnable(coreWriteEnable),
		.lookupPAddr(AccessPAddr),
		.lookupStart(pathLast),
		.remapLeaf(AccessNewLeaf),
		.lookupDone(lookupDone),
		.lookupHit(lookupHit),
		.lookupSlot(lookupSlot),
		.lookupBlock(lookupBlock),
		.slotValids(slotValids),
		.slotLeaves(slotLeaves),
		.slotRead(assignSlot),
		.slotReadEnable(readBeat),
		.slotFree(!assignDummy),
		.slotBlock(slotBlock),
		.occupancy(occupancy),
		.full(full)
	);

	stashScanTable #(.StashCapacity(StashCapacity)) scanTable (
		.Clock(Clock),
		.reset(reset),
		.AccessLeaf(AccessLeaf),
		.slotValids(slotValids),
		.slotLeaves(slotLeaves),
		.assignStart(state == stateLookup && lookupDone),
		.nextSlot(readBeat),
		.assignValid(assignValid),
		.assignSlot(assignSlot),
		.assignDummy(assignDummy)
	);

	// Last credit spent with none coming back stalls the next beat
	assert property (@(posedge Clock) disable iff (reset)
		ReadValid && creditCount == CreditWidth'(1) && !ReadCreditReturn |=> !ReadValid);

	// A hit block stays resident into writeback
	assert property (@(posedge Clock) disable iff (reset)
		state == stateLookup && lookupHit |=> slotValids[$past(lookupSlot)]);

endmodule

//--- testbench/stashTb.sv
/*
 Stash testbench. Random paths from an LCG drive the DUT, and a slot model of
 the stash predicts every return, writeback beat, credit use and status bit.
*/
module stashTb;
	timeunit 1ns;
	timeprecision 1ps;
	import stashPkg::*;

	localparam int StashCapacity = 16;
	localparam int ReadCredits = 4;
	localparam int WaitLimit = 64;

	logic Clock, reset, StartAccess;
	logic [ORAML-1:0] AccessLeaf, AccessNewLeaf;
	logic [PAddrWidth-1:0] AccessPAddr;
	stashBlock WriteBlock, ReadBlock;
	logic WriteValid, WriteReady, ReturnValid, ReadValid, ReadCreditReturn;
	returnInfo ReturnInfo;
	logic AccessDone, StashAlmostFull, StashOverflow;

	// Reference model state
	stashBlock modelSlot [StashCapacity];
	bit modelValid [StashCapacity];
	bit modelOverflow;
	int modelCredits = ReadCredits;
	int nextAddr = 1;
	int errors = 0;
	int timeouts = 0;
	logic [31:0] seed, creditSeed;

	stash #(.StashCapacity(StashCapacity), .ReadCredits(ReadCredits)) u_dut (.*);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// --------------------------------------------------
	// Random numbers and model helpers
	// --------------------------------------------------

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int unsigned nextRand();
		seed = lcgStep(seed);
		return {17'd0, seed[30:16]};
	endfunction

	// Leaf bits agree from bit 0 up, one level per matching bit
	function automatic int sharedLevels(input logic [ORAML-1:0] a, input logic [ORAML-1:0] b);
		int n;
		n = 0;
		while (n < ORAML && a[n] == b[n]) n++;
		return n;
	endfunction

	function automatic int modelOccupancy();
		int count;
		count = 0;
		for (int i = 0; i < StashCapacity; i++) count += int'(modelValid[i]);
		return count;
	endfunction

	function automatic stashBlock makeBlock(input bit farLeaves, input logic [ORAML-1:0] pathLeaf);
		stashBlock blk;
		blk.data = DataWidth'((nextRand() << 16) ^ nextRand());
		blk.leaf = ORAML'(nextRand());
		blk.paddr = '0;
		if (farLeaves) begin
			// Branches off right below the root
			blk.leaf[0] = ~pathLeaf[0];
			blk.paddr = PAddrWidth'(nextAddr);
			nextAddr++;
		end else if (nextRand() % 2 == 1) begin
			blk.paddr = PAddrWidth'(nextAddr);
			nextAddr++;
		end
		return blk;
	endfunction

	// Lowest free slot, real blocks only
	function automatic void modelInsert(input stashBlock blk);
		int slot;
		slot = -1;
		if (blk.paddr != '0) begin
			for (int i = StashCapacity - 1; i >= 0; i--) begin
				if (!modelValid[i]) slot = i;
			end
			if (slot < 0) begin
				modelOverflow = 1'b1;
			end else begin
				modelSlot[slot] = blk;
				modelValid[slot] = 1'b1;
			end
		end
	endfunction

	task automatic reportMismatch(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		$display("** Error: %s got %h, expected %h", name, got, expected);
		errors++;
	endtask

	task automatic reportTimeout(input string what);
		$display("Timeout while waiting for %s", what);
		timeouts++;
	endtask

	// --------------------------------------------------
	// Credit returns and credit accounting
	// --------------------------------------------------

	initial begin
		ReadCreditReturn = 1'b0;
		creditSeed = 32'd88 ^ 32'h5a5a;
		forever begin
			@(posedge Clock);
			creditSeed = lcgStep(creditSeed);
			// Random delay, only for credits already spent
			ReadCreditReturn <= !reset && modelCredits < ReadCredits
				&& creditSeed[17:16] == 2'b00;
		end
	end

	always @(negedge Clock) begin
		if (reset) begin
			modelCredits = ReadCredits;
		end else begin
			assert (!ReadValid || modelCredits > 0) else begin
				$display("ReadValid beat sent with no credit left");
				errors++;
			end
			modelCredits = modelCredits - int'(ReadValid) + int'(ReadCreditReturn);
		end
	end

	// --------------------------------------------------
	// Access phases
	// --------------------------------------------------

	task automatic pathRead(input bit farLeaves, input logic [ORAML-1:0] pathLeaf);
		stashBlock blk;
		int sent;
		int idle;
		bit fired;
		sent = 0;
		idle = 0;
		fired = 1'b0;
		blk = makeBlock(farLeaves, pathLeaf);
		while (sent < BlocksOnPath && timeouts == 0) begin
			@(posedge Clock);
			if (fired) begin
				modelInsert(blk);
				sent++;
				idle = 0;
				if (sent < BlocksOnPath) blk = makeBlock(farLeaves, pathLeaf);
			end
			WriteBlock <= blk;
			// Random gaps on the write bus
			WriteValid <= sent < BlocksOnPath && nextRand() % 4 != 0;
			@(negedge Clock);
			fired = WriteValid && WriteReady;
			idle++;
			if (idle > WaitLimit) reportTimeout("WriteReady");
		end
	endtask

	task automatic checkReturn(input logic [PAddrWidth-1:0] target,
			input logic [ORAML-1:0] newLeaf);
		returnInfo expected;
		int slot;
		int waited;
		expected = '0;
		slot = -1;
		for (int i = StashCapacity - 1; i >= 0; i--) begin
			if (modelValid[i] && modelSlot[i].paddr == target) slot = i;
		end
		// Returned block carries the old leaf, the slot keeps the new one
		if (slot >= 0) begin
			expected.hit = 1'b1;
			expected.block = modelSlot[slot];
			modelSlot[slot].leaf = newLeaf;
		end
		waited = 0;
		do begin
			@(negedge Clock);
			waited++;
		end while (!ReturnValid && waited < WaitLimit);
		if (!ReturnValid) begin
			reportTimeout("ReturnValid");
		end else begin
			assert (ReturnInfo === expected) else reportMismatch("ReturnInfo", ReturnInfo, expected);
		end
	endtask

	task automatic checkWriteback(input logic [ORAML-1:0] pathLeaf);
		stashBlock expected [BlocksOnPath];
		int beatLevel [BlocksOnPath];
		int pos;
		int pick;
		int beats;
		int waited;
		// Greedy fill, leaf bucket first, lowest slot wins
		pos = 0;
		for (int level = ORAML; level >= 0; level--) begin
			for (int z = 0; z < BucketZ; z++) begin
				pick = -1;
				for (int i = StashCapacity - 1; i >= 0; i--) begin
					if (modelValid[i] && sharedLevels(modelSlot[i].leaf, pathLeaf) >= level) pick = i;
				end
				expected[pos] = '0;
				expected[pos].leaf = pathLeaf;
				if (pick >= 0) begin
					expected[pos] = modelSlot[pick];
					modelValid[pick] = 1'b0;
				end
				beatLevel[pos] = level;
				pos++;
			end
		end
		beats = 0;
		waited = 0;
		// First beat may share the cycle of ReturnValid
		while (!AccessDone && timeouts == 0) begin
			if (ReadValid) begin
				if (beats >= BlocksOnPath) begin
					$display("More than one path of writeback beats");
					errors++;
				end else begin
					assert (ReadBlock === expected[beats])
						else reportMismatch("ReadBlock", ReadBlock, expected[beats]);
					assert (ReadBlock.paddr == '0
							|| sharedLevels(ReadBlock.leaf, pathLeaf) >= beatLevel[beats]) else begin
						$display("Block %h written back above its eligible level", ReadBlock.paddr);
						errors++;
					end
				end
				beats++;
				waited = 0;
			end
			@(negedge Clock);
			waited++;
			if (waited > WaitLimit) reportTimeout("a writeback beat or AccessDone");
		end
		assert (timeouts != 0 || beats == BlocksOnPath) else begin
			$display("Writeback ended after %0d beats", beats);
			errors++;
		end
	endtask

	task automatic runAccess(input bit farLeaves);
		logic [ORAML-1:0] pathLeaf;
		logic [ORAML-1:0] newLeaf;
		logic [PAddrWidth-1:0] target;
		logic almostFull;
		pathLeaf = farLeaves ? '0 : ORAML'(nextRand());
		newLeaf = ORAML'(nextRand());
		// Addresses from 0xf0 up are never written
		if (farLeaves || nextRand() % 4 == 0) begin
			target = PAddrWidth'(8'hf0 + nextRand() % 16);
		end else begin
			target = PAddrWidth'(1 + nextRand() % nextAddr);
		end
		@(posedge Clock);
		AccessLeaf <= pathLeaf;
		AccessPAddr <= target;
		AccessNewLeaf <= newLeaf;
		StartAccess <= 1'b1;
		@(posedge Clock);
		StartAccess <= 1'b0;
		// Write input opens one cycle after the start pulse
		@(negedge Clock);
		assert (WriteReady === 1'b1) else reportMismatch("WriteReady", WriteReady, 1'b1);
		pathRead(farLeaves, pathLeaf);
		if (timeouts == 0) checkReturn(target, newLeaf);
		if (timeouts == 0) checkWriteback(pathLeaf);
		if (timeouts == 0) begin
			// Status is registered one cycle behind occupancy
			@(negedge Clock);
			almostFull = modelOccupancy() >= StashCapacity - BlocksOnPath;
			assert (StashAlmostFull === almostFull)
				else reportMismatch("StashAlmostFull", StashAlmostFull, almostFull);
			assert (StashOverflow === modelOverflow)
				else reportMismatch("StashOverflow", StashOverflow, modelOverflow);
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------

	initial begin
		seed = 32'd88;
		reset = 1'b1;
		StartAccess = 1'b0;
		AccessLeaf = '0;
		AccessPAddr = '0;
		AccessNewLeaf = '0;
		WriteBlock = '0;
		WriteValid = 1'b0;
		repeat (8) @(posedge Clock);
		reset <= 1'b0;
		repeat (2) @(posedge Clock);

		// Mixed paths, hits and misses
		for (int n = 0; n < 16 && timeouts == 0; n++) runAccess(1'b0);

		// Only the root bucket takes these blocks, so the stash fills up
		for (int n = 0; n < 8 && !modelOverflow && timeouts == 0; n++) runAccess(1'b1);
		assert (timeouts != 0 || modelOverflow) else begin
			$display("Stash never reached the overflow point");
			errors++;
		end
		// Overflow is sticky
		if (timeouts == 0) runAccess(1'b1);

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- pathOramStash.f
design/stashPkg.sv
design/stashCore.sv
design/stashScanTable.sv
design/stash.sv
testbench/stashTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = stashTb
FILELIST = pathOramStash.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
